// File: Makefile
OBJ_DIR := obj_dir

sim:
	verilator --binary --timing --assert --top-module riscv_sys_tb -f project.f \
		-Mdir $(OBJ_DIR) -o riscv_sys_sim
	$(OBJ_DIR)/riscv_sys_sim +verilator+error+limit+1000 | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

.PHONY: sim clean

// File: project.f
+incdir+src
src/riscv_sys_pkg.sv
src/desc_fifo.sv
src/boot_sequencer.sv
src/core_ctrl_regs.sv
src/rx_slot_alloc.sv
src/riscv_sys_top.sv
tb/riscv_sys_checker.sv
tb/riscv_sys_tb.sv

// File: src/boot_sequencer.sv
`include "riscv_sys_macros.svh"

module boot_sequencer (
  input  logic                     clk,
  input  logic                     rst,
  // AXI4-Lite write master
  output riscv_sys_pkg::axil_aw_t  aw,
  output logic                     aw_valid,
  input  logic                     aw_ready,
  output riscv_sys_pkg::axil_w_t   w,
  output logic                     w_valid,
  input  logic                     w_ready,
  input  riscv_sys_pkg::axil_b_t   b,
  input  logic                     b_valid,
  output logic                     b_ready,
  // Slot address table
  output logic [`SLOT_NO_W-1:0]    slot_wr_no,
  output logic [`SLOT_ADDR_W-1:0]  slot_wr_addr,
  output logic                     slot_wr_valid,
  // Receive descriptor injection
  output riscv_sys_pkg::rx_desc_t  inject_desc,
  output logic                     inject_valid,
  input  logic                     inject_ready,
  output logic                     tx_enable,
  output logic                     rx_enable
);

  localparam int DELAY_W = $clog2(`BOOT_DELAY);

  riscv_sys_pkg::boot_state_e state;
  logic [DELAY_W-1:0]    delay_cnt;
  logic [`CORE_NO_W-1:0] core_sel;
  logic                  b_fire;
  logic                  aw_done;
  logic                  w_done;
  logic [`SLOT_NO_W:0]   slot_idx;
  logic [`CORE_NO_W-1:0] inj_core;
  logic [`SLOT_NO_W-1:0] inj_slot;
  logic                  inj_done;

  // Payloads only change when core_sel moves, which is after the response
  assign aw = '{addr: {core_sel, `CORE_CTRL_OFFSET}, prot: 3'b010};
  assign w  = '{data: '0, strb: '1};

  assign b_ready = 1'b1;
  assign b_fire  = b_valid && b_ready;
  assign aw_done = !aw_valid || aw_ready;
  assign w_done  = !w_valid || w_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= riscv_sys_pkg::WAIT_START;
      delay_cnt <= '0;
      core_sel  <= '0;
      aw_valid  <= 1'b0;
      w_valid   <= 1'b0;
    end else begin
      unique case (state)
        riscv_sys_pkg::WAIT_START: begin
          delay_cnt <= delay_cnt + DELAY_W'(1);
          if (delay_cnt == DELAY_W'(`BOOT_DELAY - 1)) begin
            state    <= riscv_sys_pkg::SEND_WRITE;
            aw_valid <= 1'b1;
            w_valid  <= 1'b1;
          end
        end
        riscv_sys_pkg::SEND_WRITE: begin
          // AW and W can be taken in different cycles
          if (aw_valid && aw_ready) begin
            aw_valid <= 1'b0;
          end
          if (w_valid && w_ready) begin
            w_valid <= 1'b0;
          end
          if (aw_done && w_done) begin
            state <= riscv_sys_pkg::WAIT_RESP;
          end
        end
        riscv_sys_pkg::WAIT_RESP: begin
          if (b_fire) begin
            if (b.resp != riscv_sys_pkg::OKAY) begin
              // An error response sends the same release again
              state    <= riscv_sys_pkg::SEND_WRITE;
              aw_valid <= 1'b1;
              w_valid  <= 1'b1;
            end else if (core_sel == `CORE_NO_W'(`RISCV_CORES - 1)) begin
              state <= riscv_sys_pkg::RUNNING;
            end else begin
              core_sel <= core_sel + `CORE_NO_W'(1);
              state    <= riscv_sys_pkg::SEND_WRITE;
              aw_valid <= 1'b1;
              w_valid  <= 1'b1;
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

  assign tx_enable = (state == riscv_sys_pkg::RUNNING);
  assign rx_enable = (state == riscv_sys_pkg::RUNNING);

  // The slot table takes one entry per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_idx      <= '0;
      slot_wr_valid <= 1'b0;
    end else if (slot_idx < (`SLOT_NO_W + 1)'(`RISCV_SLOTS)) begin
      slot_idx      <= slot_idx + (`SLOT_NO_W + 1)'(1);
      slot_wr_valid <= 1'b1;
      slot_wr_no    <= slot_idx[`SLOT_NO_W-1:0];
      slot_wr_addr  <= `SLOT_ADDR_W'(`FIRST_SLOT_ADDR + `SLOT_ADDR_STEP * slot_idx);
    end else begin
      slot_wr_valid <= 1'b0;
    end
  end

  // Descriptors go out with the core number moving fastest
  always_ff @(posedge clk) begin
    if (rst) begin
      inj_core     <= '0;
      inj_slot     <= '0;
      inj_done     <= 1'b0;
      inject_valid <= 1'b0;
    end else if (!inject_valid && !inj_done) begin
      inject_valid <= 1'b1;
    end else if (inject_valid && inject_ready) begin
      if (inj_core == `CORE_NO_W'(`RISCV_CORES - 1)) begin
        inj_core <= '0;
        if (inj_slot == `SLOT_NO_W'(`RISCV_SLOTS - 1)) begin
          inject_valid <= 1'b0;
          inj_done     <= 1'b1;
        end else begin
          inj_slot <= inj_slot + `SLOT_NO_W'(1);
        end
      end else begin
        inj_core <= inj_core + `CORE_NO_W'(1);
      end
    end
  end

  assign inject_desc = '{core: inj_core, slot: inj_slot};

endmodule

// File: src/core_ctrl_regs.sv
`include "riscv_sys_macros.svh"

module core_ctrl_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  riscv_sys_pkg::axil_aw_t aw,
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  riscv_sys_pkg::axil_w_t  w,
  input  logic                    w_valid,
  output logic                    w_ready,
  output riscv_sys_pkg::axil_b_t  b,
  output logic                    b_valid,
  input  logic                    b_ready,
  output logic [`RISCV_CORES-1:0] core_reset
);

  riscv_sys_pkg::axil_resp_e b_resp;
  logic                      accept;
  logic [`CORE_NO_W-1:0]     wr_core;
  logic [`AXIL_OFFSET_W-1:0] wr_offset;

  // Address and data are taken together, and only with no response pending
  assign aw_ready = w_valid && !b_valid;
  assign w_ready  = aw_valid && !b_valid;
  assign accept   = aw_valid && w_valid && !b_valid;

  assign wr_core   = aw.addr[`AXIL_ADDR_W-1 -: `CORE_NO_W];
  assign wr_offset = aw.addr[`AXIL_OFFSET_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      b_valid    <= 1'b0;
      core_reset <= '1;
    end else begin
      if (accept) begin
        b_valid <= 1'b1;
        if (wr_offset == `CORE_CTRL_OFFSET && w.strb[0]) begin
          core_reset[wr_core] <= w.data[0];
        end
      end else if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      if (wr_offset == `CORE_CTRL_OFFSET) begin
        b_resp <= riscv_sys_pkg::OKAY;
      end else begin
        b_resp <= riscv_sys_pkg::SLVERR;
      end
    end
  end

  assign b = '{resp: b_resp};

endmodule

// File: src/desc_fifo.sv
`include "riscv_sys_macros.svh"

module desc_fifo #(
  parameter int DEPTH = `RISCV_CORES * `RISCV_SLOTS
) (
  input  logic                    clk,
  input  logic                    rst,
  input  riscv_sys_pkg::rx_desc_t push_data,
  input  logic                    push_valid,
  input  logic                    pop,
  output riscv_sys_pkg::rx_desc_t pop_data,
  output logic                    empty,
  output logic                    full
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  riscv_sys_pkg::rx_desc_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_valid && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      if (do_push && !do_pop) begin
        count <= count + CNT_W'(1);
      end else if (do_pop && !do_push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  assign pop_data = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));

endmodule

// File: src/riscv_sys_macros.svh
`ifndef RISCV_SYS_MACROS_SVH
`define RISCV_SYS_MACROS_SVH

// Core and receive slot counts
`define RISCV_CORES      8
`define RISCV_SLOTS      16
`define CORE_NO_W        3
`define SLOT_NO_W        4

// Slot buffer address layout
`define SLOT_ADDR_W      7
`define FIRST_SLOT_ADDR  7'h40
`define SLOT_ADDR_STEP   4

// The top bits of an AXI4-Lite address select the core window
`define AXIL_ADDR_W      19
`define AXIL_OFFSET_W    16
`define AXIL_DATA_W      32
`define AXIL_STRB_W      (`AXIL_DATA_W / 8)

// Reset register offset inside each core window
`define CORE_CTRL_OFFSET 16'hFFFC

// Start-up wait in clock cycles
`define BOOT_DELAY       100

`endif

// File: src/riscv_sys_pkg.sv
`include "riscv_sys_macros.svh"

package riscv_sys_pkg;

  // One receive buffer is named by its core and slot
  typedef struct packed {
    logic [`CORE_NO_W-1:0] core;
    logic [`SLOT_NO_W-1:0] slot;
  } rx_desc_t;

  // Result handed back for one packet request
  typedef struct packed {
    rx_desc_t               desc;
    logic [`SLOT_ADDR_W-1:0] slot_addr;
  } rx_grant_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [2:0]              prot;
  } axil_aw_t;

  typedef struct packed {
    logic [`AXIL_DATA_W-1:0] data;
    logic [`AXIL_STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  typedef enum logic [1:0] {
    WAIT_START,
    SEND_WRITE,
    WAIT_RESP,
    RUNNING
  } boot_state_e;

endpackage

// File: src/riscv_sys_top.sv
`include "riscv_sys_macros.svh"

module riscv_sys_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rx_req_valid,
  output logic                     rx_req_ready,
  output riscv_sys_pkg::rx_grant_t rx_grant,
  output logic                     rx_grant_valid,
  input  riscv_sys_pkg::rx_desc_t  rel_desc,
  input  logic                     rel_valid,
  output logic [`RISCV_CORES-1:0]  core_reset,
  output logic                     tx_enable,
  output logic                     rx_enable
);

  riscv_sys_pkg::axil_aw_t axil_aw;
  riscv_sys_pkg::axil_w_t  axil_w;
  riscv_sys_pkg::axil_b_t  axil_b;
  logic                    axil_aw_valid;
  logic                    axil_aw_ready;
  logic                    axil_w_valid;
  logic                    axil_w_ready;
  logic                    axil_b_valid;
  logic                    axil_b_ready;

  logic [`SLOT_NO_W-1:0]   slot_wr_no;
  logic [`SLOT_ADDR_W-1:0] slot_wr_addr;
  logic                    slot_wr_valid;
  riscv_sys_pkg::rx_desc_t inject_desc;
  logic                    inject_valid;
  logic                    inject_ready;

  boot_sequencer u_boot_sequencer (
    .clk           (clk),
    .rst           (rst),
    .aw            (axil_aw),
    .aw_valid      (axil_aw_valid),
    .aw_ready      (axil_aw_ready),
    .w             (axil_w),
    .w_valid       (axil_w_valid),
    .w_ready       (axil_w_ready),
    .b             (axil_b),
    .b_valid       (axil_b_valid),
    .b_ready       (axil_b_ready),
    .slot_wr_no    (slot_wr_no),
    .slot_wr_addr  (slot_wr_addr),
    .slot_wr_valid (slot_wr_valid),
    .inject_desc   (inject_desc),
    .inject_valid  (inject_valid),
    .inject_ready  (inject_ready),
    .tx_enable     (tx_enable),
    .rx_enable     (rx_enable)
  );

  core_ctrl_regs u_core_ctrl_regs (
    .clk        (clk),
    .rst        (rst),
    .aw         (axil_aw),
    .aw_valid   (axil_aw_valid),
    .aw_ready   (axil_aw_ready),
    .w          (axil_w),
    .w_valid    (axil_w_valid),
    .w_ready    (axil_w_ready),
    .b          (axil_b),
    .b_valid    (axil_b_valid),
    .b_ready    (axil_b_ready),
    .core_reset (core_reset)
  );

  rx_slot_alloc u_rx_slot_alloc (
    .clk            (clk),
    .rst            (rst),
    .rx_enable      (rx_enable),
    .slot_wr_no     (slot_wr_no),
    .slot_wr_addr   (slot_wr_addr),
    .slot_wr_valid  (slot_wr_valid),
    .inject_desc    (inject_desc),
    .inject_valid   (inject_valid),
    .inject_ready   (inject_ready),
    .rel_desc       (rel_desc),
    .rel_valid      (rel_valid),
    .rx_req_valid   (rx_req_valid),
    .rx_req_ready   (rx_req_ready),
    .rx_grant       (rx_grant),
    .rx_grant_valid (rx_grant_valid)
  );

endmodule

// File: src/rx_slot_alloc.sv
`include "riscv_sys_macros.svh"

module rx_slot_alloc (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rx_enable,
  input  logic [`SLOT_NO_W-1:0]    slot_wr_no,
  input  logic [`SLOT_ADDR_W-1:0]  slot_wr_addr,
  input  logic                     slot_wr_valid,
  input  riscv_sys_pkg::rx_desc_t  inject_desc,
  input  logic                     inject_valid,
  output logic                     inject_ready,
  input  riscv_sys_pkg::rx_desc_t  rel_desc,
  input  logic                     rel_valid,
  input  logic                     rx_req_valid,
  output logic                     rx_req_ready,
  output riscv_sys_pkg::rx_grant_t rx_grant,
  output logic                     rx_grant_valid
);

  logic [`SLOT_ADDR_W-1:0] slot_table [`RISCV_SLOTS];

  riscv_sys_pkg::rx_desc_t push_data;
  riscv_sys_pkg::rx_desc_t head;
  logic                    push_valid;
  logic                    req_fire;
  logic                    q_empty;
  logic                    q_full;

  always_ff @(posedge clk) begin
    if (slot_wr_valid) begin
      slot_table[slot_wr_no] <= slot_wr_addr;
    end
  end

  // Releases win the write port and injection stalls for that cycle
  assign inject_ready = !rel_valid && !q_full;
  assign push_data    = rel_valid ? rel_desc : inject_desc;
  assign push_valid   = rel_valid || (inject_valid && inject_ready);

  assign rx_req_ready = rx_enable && !q_empty;
  assign req_fire     = rx_req_valid && rx_req_ready;

  desc_fifo u_desc_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_data  (push_data),
    .push_valid (push_valid),
    .pop        (req_fire),
    .pop_data   (head),
    .empty      (q_empty),
    .full       (q_full)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_grant_valid <= 1'b0;
    end else begin
      rx_grant_valid <= req_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      rx_grant <= '{desc: head, slot_addr: slot_table[head.slot]};
    end
  end

endmodule

// File: tb/riscv_sys_checker.sv
module riscv_sys_checker (
  input logic                    clk,
  input logic                    rst,
  input riscv_sys_pkg::axil_aw_t axil_aw,
  input logic                    axil_aw_valid,
  input logic                    axil_aw_ready,
  input riscv_sys_pkg::axil_w_t  axil_w,
  input logic                    axil_w_valid,
  input logic                    axil_w_ready,
  input logic                    tx_enable,
  input logic                    rx_enable,
  input logic                    rx_req_valid,
  input logic                    rx_req_ready,
  input logic                    rx_grant_valid
);

  int failures = 0;

  // A stalled AXI4-Lite channel keeps valid up and its payload unchanged
  a_aw_stable: assert property (@(posedge clk) disable iff (rst)
    axil_aw_valid && !axil_aw_ready |=> axil_aw_valid && $stable(axil_aw))
    else begin
      failures++;
      $error("AW payload or valid changed before the slave took it");
    end

  a_w_stable: assert property (@(posedge clk) disable iff (rst)
    axil_w_valid && !axil_w_ready |=> axil_w_valid && $stable(axil_w))
    else begin
      failures++;
      $error("W payload or valid changed before the slave took it");
    end

  a_tx_enable_held: assert property (@(posedge clk) disable iff (rst)
    tx_enable |=> tx_enable)
    else begin
      failures++;
      $error("tx_enable fell after rising");
    end

  a_req_ready_gated: assert property (@(posedge clk) disable iff (rst)
    !rx_enable |-> !rx_req_ready)
    else begin
      failures++;
      $error("rx_req_ready high while rx_enable is low");
    end

  // Grant valid follows each accepted request by exactly one cycle
  a_grant_after_req: assert property (@(posedge clk) disable iff (rst)
    rx_req_valid && rx_req_ready |=> rx_grant_valid)
    else begin
      failures++;
      $error("No grant one cycle after an accepted request");
    end

  a_grant_only_after_req: assert property (@(posedge clk) disable iff (rst)
    rx_grant_valid |-> $past(rx_req_valid && rx_req_ready))
    else begin
      failures++;
      $error("Grant without an accepted request the cycle before");
    end

endmodule

bind riscv_sys_top riscv_sys_checker u_riscv_sys_checker (
  .clk            (clk),
  .rst            (rst),
  .axil_aw        (axil_aw),
  .axil_aw_valid  (axil_aw_valid),
  .axil_aw_ready  (axil_aw_ready),
  .axil_w         (axil_w),
  .axil_w_valid   (axil_w_valid),
  .axil_w_ready   (axil_w_ready),
  .tx_enable      (tx_enable),
  .rx_enable      (rx_enable),
  .rx_req_valid   (rx_req_valid),
  .rx_req_ready   (rx_req_ready),
  .rx_grant_valid (rx_grant_valid)
);

// File: tb/riscv_sys_tb.sv
`include "riscv_sys_macros.svh"

module riscv_sys_tb;

  localparam int TOTAL_DESCS    = `RISCV_CORES * `RISCV_SLOTS;
  localparam int RELEASES       = 20;
  localparam int BOOT_TIMEOUT   = `BOOT_DELAY + 64;
  localparam int ENABLE_TIMEOUT = 16;
  localparam int REQ_TIMEOUT    = 32;
  localparam int GRANT_TIMEOUT  = 32;

  logic                     clk;
  logic                     rst;
  logic                     rx_req_valid;
  logic                     rx_req_ready;
  riscv_sys_pkg::rx_grant_t rx_grant;
  logic                     rx_grant_valid;
  riscv_sys_pkg::rx_desc_t  rel_desc;
  logic                     rel_valid;
  logic [`RISCV_CORES-1:0]  core_reset;
  logic                     tx_enable;
  logic                     rx_enable;

  logic [31:0]             lfsr_state;
  riscv_sys_pkg::rx_desc_t model_q [$];
  riscv_sys_pkg::rx_desc_t pool [$];
  riscv_sys_pkg::rx_desc_t next_desc;
  riscv_sys_pkg::rx_desc_t popped_desc;
  int check_count = 0;
  int error_count = 0;
  int grant_count = 0;
  int test_checks = 0;
  int test_errors = 0;

  riscv_sys_top UUT (
    .clk            (clk),
    .rst            (rst),
    .rx_req_valid   (rx_req_valid),
    .rx_req_ready   (rx_req_ready),
    .rx_grant       (rx_grant),
    .rx_grant_valid (rx_grant_valid),
    .rel_desc       (rel_desc),
    .rel_valid      (rel_valid),
    .core_reset     (core_reset),
    .tx_enable      (tx_enable),
    .rx_enable      (rx_enable)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10;
      clk = ~clk;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    int          i;
    v = 0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Slot i sits at the first slot address plus i address steps
  function automatic riscv_sys_pkg::rx_grant_t expected_grant(
    input riscv_sys_pkg::rx_desc_t d
  );
    riscv_sys_pkg::rx_grant_t g;
    g.desc      = d;
    g.slot_addr = `SLOT_ADDR_W'(`FIRST_SLOT_ADDR + `SLOT_ADDR_STEP * d.slot);
    return g;
  endfunction

  task automatic check_grant(input riscv_sys_pkg::rx_grant_t got,
                             input riscv_sys_pkg::rx_grant_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERR @%0t: %s core %0d slot %0d addr 'h%0h, expected core %0d slot %0d addr 'h%0h",
               $time, what, got.desc.core, got.desc.slot, got.slot_addr,
               exp.desc.core, exp.desc.slot, exp.slot_addr);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_mask(input logic [`RISCV_CORES-1:0] got,
                            input logic [`RISCV_CORES-1:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    error_count++;
    $display("Timed out at %0t while waiting for %s", $time, what);
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d checks, %0d errors", name, check_count - test_checks,
             error_count - test_errors);
    test_checks = check_count;
    test_errors = error_count;
  endtask

  // Every grant takes the oldest descriptor in the model queue
  always @(negedge clk) begin
    if (!rst && rx_grant_valid === 1'b1) begin
      grant_count++;
      if (model_q.size() == 0) begin
        error_count++;
        $display("Unexpected grant at %0t with no descriptor left in the model", $time);
      end else begin
        popped_desc = model_q.pop_front();
        check_grant(rx_grant, expected_grant(popped_desc), "grant");
      end
    end
  end

  task automatic wait_core_release(input int n);
    logic [`RISCV_CORES-1:0] mask;
    int                      cycles;
    mask   = {`RISCV_CORES{1'b1}} << (n + 1);
    cycles = 0;
    while (core_reset[n] !== 1'b0 && cycles < BOOT_TIMEOUT) begin
      check_bit(tx_enable, 1'b0, "tx_enable during boot");
      check_bit(rx_enable, 1'b0, "rx_enable during boot");
      @(negedge clk);
      cycles++;
    end
    if (core_reset[n] !== 1'b0) begin
      note_timeout($sformatf("release of core %0d", n));
    end else begin
      check_mask(core_reset, mask, "core_reset");
      check_bit(tx_enable, 1'b0, "tx_enable at core release");
    end
  endtask

  task automatic wait_enables();
    int cycles;
    cycles = 0;
    while (tx_enable !== 1'b1 && cycles < ENABLE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (tx_enable !== 1'b1) begin
      note_timeout("tx_enable");
    end else begin
      check_bit(rx_enable, 1'b1, "rx_enable after boot");
      check_mask(core_reset, '0, "core_reset after boot");
    end
  endtask

  // Called and returns 2 units after a rising edge
  task automatic issue_request();
    int   cycles;
    logic taken;
    cycles = 0;
    taken  = 1'b0;
    rx_req_valid = 1'b1;
    while (!taken && cycles < REQ_TIMEOUT) begin
      @(negedge clk);
      taken = (rx_req_ready === 1'b1);
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!taken) begin
      note_timeout("rx_req_ready");
    end
  endtask

  task automatic wait_grants(input int target);
    int cycles;
    cycles = 0;
    while (grant_count < target && cycles < GRANT_TIMEOUT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (grant_count < target) begin
      note_timeout($sformatf("grant %0d", target));
    end
  endtask

  task automatic release_one(input riscv_sys_pkg::rx_desc_t d);
    rel_desc  = d;
    rel_valid = 1'b1;
    model_q.push_back(d);
    @(posedge clk);
    #2;
    rel_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    int c;
    int s;
    int idx;
    rst          = 1'b1;
    rx_req_valid = 1'b0;
    rel_valid    = 1'b0;
    rel_desc     = '0;
    lfsr_state   = 32'h8cd1;
    for (s = 0; s < `RISCV_SLOTS; s++) begin
      for (c = 0; c < `RISCV_CORES; c++) begin
        next_desc = '{core: `CORE_NO_W'(c), slot: `SLOT_NO_W'(s)};
        model_q.push_back(next_desc);
        pool.push_back(next_desc);
      end
    end
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    @(negedge clk);
    check_mask(core_reset, '1, "core_reset after reset");
    check_bit(tx_enable, 1'b0, "tx_enable after reset");
    check_bit(rx_enable, 1'b0, "rx_enable after reset");
    check_bit(rx_req_ready, 1'b0, "rx_req_ready after reset");
    report_test("reset values");

    for (c = 0; c < `RISCV_CORES; c++) begin
      wait_core_release(c);
    end
    wait_enables();
    report_test("boot order");

    // A zero gap keeps the request up for back-to-back grants
    @(posedge clk);
    #2;
    for (idx = 0; idx < TOTAL_DESCS; idx++) begin
      issue_request();
      s = int'(take_bits(2));
      if (s != 0) begin
        rx_req_valid = 1'b0;
        idle_cycles(s);
      end
    end
    rx_req_valid = 1'b0;
    wait_grants(TOTAL_DESCS);
    report_test("initial allocation");

    rx_req_valid = 1'b1;
    repeat (16) begin
      @(negedge clk);
      check_bit(rx_req_ready, 1'b0, "rx_req_ready with empty queue");
    end
    report_test("exhaustion");

    // The first releases queue up and the rest meet a pending request
    @(posedge clk);
    #2;
    rx_req_valid = 1'b0;
    for (idx = 0; idx < RELEASES; idx++) begin
      if (idx == 8) begin
        rx_req_valid = 1'b1;
      end
      c = int'(take_bits(7) % pool.size());
      release_one(pool[c]);
      pool.delete(c);
      idle_cycles(int'(take_bits(2)));
    end
    wait_grants(TOTAL_DESCS + RELEASES);
    rx_req_valid = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_bit(rx_req_ready, 1'b0, "rx_req_ready after recycling");
    end
    check_bit(model_q.size() == 0, 1'b1, "model queue drained");
    report_test("recycling");

    error_count = error_count + UUT.u_riscv_sys_checker.failures;
    $display("total: %0d checks, %0d grants, %0d assertion failures, %0d errors",
             check_count, grant_count, UUT.u_riscv_sys_checker.failures, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
